// ==== Makefile ====
# Verilator build and run for the serial terminal text path

VERILATOR ?= verilator
FILELIST  ?= VirtualConsole.f
TOP       ?= VirtualConsoleTb
LINT_TOP  ?= VirtualConsole
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

SOURCES := $(wildcard design/*.sv dv/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== VirtualConsole.f ====
+incdir+include
design/ConsolePkg.sv
design/UartReceiver.sv
design/Vt100Parser.sv
design/TextRam.sv
design/TextScanner.sv
design/VirtualConsole.sv
dv/VirtualConsoleTb.sv

// ==== design/ConsolePkg.sv ====
`default_nettype none

package ConsolePkg;

    // UART receiver FSM
    typedef enum logic [1:0] {
        RxIdle,
        RxStart,
        RxData,
        RxStop
    } RxState_t;

    // VT100 parser FSM
    typedef enum logic [1:0] {
        Ground,
        Escape,
        Csi,
        Clearing
    } ParserState_t;

    // Frame scanner FSM
    typedef enum logic {
        ScanIdle,
        Scan
    } ScanState_t;

endpackage

`default_nettype wire

// ==== design/TextRam.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module TextRam(
    input  wire logic                   clk,
    input  wire logic                   writeEn,
    input  wire logic [`ADDR_BITS-1:0]  writeAddr,
    input  wire logic [7:0]             writeChar,
    input  wire logic [`ADDR_BITS-1:0]  readAddr,
    output logic [7:0]                  readChar
    );

    // One byte per character cell
    logic [7:0] mem [0:`COLS*`ROWS-1];

    // Same-address read and write returns the old value
    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeChar;
        end
        readChar <= mem[readAddr];
    end

endmodule

`default_nettype wire

// ==== design/TextScanner.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module TextScanner(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   frameStart,
    input  wire logic [`ROW_BITS-1:0]   cursorRow,
    input  wire logic [`COL_BITS-1:0]   cursorCol,
    output logic [`ADDR_BITS-1:0]       readAddr,
    input  wire logic [7:0]             readChar,
    output logic                        cellValid,
    output logic [7:0]                  cellChar,
    output logic [`ROW_BITS-1:0]        cellRow,
    output logic [`COL_BITS-1:0]        cellCol,
    output logic                        cursorCell
    );

    ConsolePkg::ScanState_t state;

    logic [`ADDR_BITS-1:0] cellCount;
    logic [`ROW_BITS-1:0]  countRow;
    logic [`COL_BITS-1:0]  countCol;

    assign readAddr = cellCount;
    assign countRow = cellCount[`ADDR_BITS-1:`COL_BITS];
    assign countCol = cellCount[`COL_BITS-1:0];

    // RAM output is already one cycle behind the address
    assign cellChar = readChar;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= ConsolePkg::ScanIdle;
            cellCount  <= '0;
            cellValid  <= 1'b0;
            cursorCell <= 1'b0;
        end else begin
            cellValid  <= (state == ConsolePkg::Scan);
            cursorCell <= (state == ConsolePkg::Scan) &&
                          (countRow == cursorRow) && (countCol == cursorCol);
            case (state)
                ConsolePkg::ScanIdle: begin
                    cellCount <= '0;
                    if (frameStart) begin
                        state <= ConsolePkg::Scan;
                    end
                end
                ConsolePkg::Scan: begin
                    // frameStart is ignored until the last cell
                    cellCount <= cellCount + 1'b1;
                    if (cellCount == `COLS * `ROWS - 1) begin
                        state <= ConsolePkg::ScanIdle;
                    end
                end
                default: state <= ConsolePkg::ScanIdle;
            endcase
        end
    end

    // Row and column match the read data stage
    always_ff @(posedge clk) begin
        cellRow <= countRow;
        cellCol <= countCol;
    end

    assert property (@(posedge clk) disable iff (!rstN)
        cellValid ##1 cellValid |-> {cellRow, cellCol} == $past({cellRow, cellCol}) + 1'b1)
        else $error("scan skipped or repeated a cell");

endmodule

`default_nettype wire

// ==== design/UartReceiver.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module UartReceiver(
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire logic       rxd,
    output logic            byteReady,
    output logic [7:0]      byteData
    );

    localparam int CntBits = $clog2(`CLKS_PER_BIT);
    localparam logic [CntBits-1:0] HalfBit = CntBits'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [CntBits-1:0] FullBit = CntBits'(`CLKS_PER_BIT - 1);

    ConsolePkg::RxState_t state;

    logic               rxdMeta;
    logic               rxdSync;
    logic               rxdPrev;
    logic [CntBits-1:0] clkCount;
    logic [2:0]         bitIndex;
    logic [7:0]         shiftReg;
    logic               bitTick;

    // Line idles high, so the synchronizer resets to one
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rxdMeta <= 1'b1;
            rxdSync <= 1'b1;
            rxdPrev <= 1'b1;
        end else begin
            rxdMeta <= rxd;
            rxdSync <= rxdMeta;
            rxdPrev <= rxdSync;
        end
    end

    // Middle of a data or stop bit
    assign bitTick = (clkCount == FullBit);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= ConsolePkg::RxIdle;
            clkCount  <= '0;
            bitIndex  <= '0;
            byteReady <= 1'b0;
        end else begin
            byteReady <= 1'b0;
            case (state)
                ConsolePkg::RxIdle: begin
                    clkCount <= '0;
                    if (rxdPrev && !rxdSync) begin
                        state <= ConsolePkg::RxStart;
                    end
                end
                ConsolePkg::RxStart: begin
                    if (clkCount == HalfBit) begin
                        // Glitch shorter than half a bit goes back to idle
                        clkCount <= '0;
                        bitIndex <= '0;
                        state    <= rxdSync ? ConsolePkg::RxIdle : ConsolePkg::RxData;
                    end else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
                ConsolePkg::RxData: begin
                    if (bitTick) begin
                        clkCount <= '0;
                        bitIndex <= bitIndex + 3'd1;
                        if (bitIndex == 3'd7) begin
                            state <= ConsolePkg::RxStop;
                        end
                    end else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
                ConsolePkg::RxStop: begin
                    if (bitTick) begin
                        clkCount  <= '0;
                        byteReady <= rxdSync;
                        state     <= ConsolePkg::RxIdle;
                    end else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
                default: state <= ConsolePkg::RxIdle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == ConsolePkg::RxData && bitTick) begin
            shiftReg <= {rxdSync, shiftReg[7:1]};
        end
        if (state == ConsolePkg::RxStop && bitTick && rxdSync) begin
            byteData <= shiftReg;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) byteReady |=> !byteReady)
        else $error("byteReady held for more than one cycle");

endmodule

`default_nettype wire

// ==== design/VirtualConsole.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module VirtualConsole(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   rxd,
    input  wire logic                   frameStart,
    output logic                        cellValid,
    output logic [7:0]                  cellChar,
    output logic [`ROW_BITS-1:0]        cellRow,
    output logic [`COL_BITS-1:0]        cellCol,
    output logic                        cursorCell
    );

    // UART receiver to parser
    logic                  byteReady;
    logic [7:0]            byteData;

    // Parser to text RAM and scanner
    logic                  writeEn;
    logic [`ADDR_BITS-1:0] writeAddr;
    logic [7:0]            writeChar;
    logic [`ROW_BITS-1:0]  cursorRow;
    logic [`COL_BITS-1:0]  cursorCol;

    // Scanner read port
    logic [`ADDR_BITS-1:0] readAddr;
    logic [7:0]            readChar;

    UartReceiver uartReceiver(
        .clk,
        .rstN,
        .rxd,
        .byteReady,
        .byteData
    );

    Vt100Parser vt100Parser(
        .clk,
        .rstN,
        .byteReady,
        .byteData,
        .writeEn,
        .writeAddr,
        .writeChar,
        .cursorRow,
        .cursorCol
    );

    TextRam textRam(
        .clk,
        .writeEn,
        .writeAddr,
        .writeChar,
        .readAddr,
        .readChar
    );

    TextScanner textScanner(
        .clk,
        .rstN,
        .frameStart,
        .cursorRow,
        .cursorCol,
        .readAddr,
        .readChar,
        .cellValid,
        .cellChar,
        .cellRow,
        .cellCol,
        .cursorCell
    );

endmodule

`default_nettype wire

// ==== design/Vt100Parser.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module Vt100Parser(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   byteReady,
    input  wire logic [7:0]             byteData,
    output logic                        writeEn,
    output logic [`ADDR_BITS-1:0]       writeAddr,
    output logic [7:0]                  writeChar,
    output logic [`ROW_BITS-1:0]        cursorRow,
    output logic [`COL_BITS-1:0]        cursorCol
    );

    localparam logic [7:0] CharBs     = 8'h08;
    localparam logic [7:0] CharLf     = 8'h0A;
    localparam logic [7:0] CharCr     = 8'h0D;
    localparam logic [7:0] CharEsc    = 8'h1B;
    localparam logic [7:0] CharSpace  = 8'h20;
    localparam logic [7:0] CharTilde  = 8'h7E;
    localparam logic [7:0] CharLBrack = 8'h5B;
    localparam logic [7:0] CharH      = 8'h48;
    localparam logic [7:0] CharJ      = 8'h4A;
    localparam logic [7:0] CharZero   = 8'h30;
    localparam logic [7:0] CharNine   = 8'h39;

    ConsolePkg::ParserState_t state;

    logic [3:0]            csiParam;
    logic [`ADDR_BITS-1:0] clearCount;
    logic                  printable;
    logic                  isDigit;

    // No scrolling so the last row wraps back to the top
    function automatic logic [`ROW_BITS-1:0] wrapRow(input logic [`ROW_BITS-1:0] row);
        return (row == `ROWS - 1) ? '0 : row + 1'b1;
    endfunction

    assign printable = (byteData >= CharSpace) && (byteData <= CharTilde);
    assign isDigit   = (byteData >= CharZero) && (byteData <= CharNine);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= ConsolePkg::Clearing;
            clearCount <= '0;
            csiParam   <= '0;
            cursorRow  <= '0;
            cursorCol  <= '0;
            writeEn    <= 1'b0;
        end else begin
            writeEn <= 1'b0;
            case (state)
                ConsolePkg::Ground: begin
                    if (byteReady) begin
                        if (printable) begin
                            writeEn <= 1'b1;
                            if (cursorCol == `COLS - 1) begin
                                cursorCol <= '0;
                                cursorRow <= wrapRow(cursorRow);
                            end else begin
                                cursorCol <= cursorCol + 1'b1;
                            end
                        end else if (byteData == CharCr) begin
                            cursorCol <= '0;
                        end else if (byteData == CharLf) begin
                            cursorRow <= wrapRow(cursorRow);
                        end else if (byteData == CharBs) begin
                            if (cursorCol != '0) begin
                                cursorCol <= cursorCol - 1'b1;
                            end
                        end else if (byteData == CharEsc) begin
                            state <= ConsolePkg::Escape;
                        end
                    end
                end
                ConsolePkg::Escape: begin
                    if (byteReady) begin
                        csiParam <= '0;
                        state    <= (byteData == CharLBrack) ? ConsolePkg::Csi
                                                             : ConsolePkg::Ground;
                    end
                end
                ConsolePkg::Csi: begin
                    if (byteReady) begin
                        if (isDigit) begin
                            // One digit parameter, last one wins
                            csiParam <= byteData[3:0];
                        end else if (byteData == CharH) begin
                            cursorRow <= '0;
                            cursorCol <= '0;
                            state     <= ConsolePkg::Ground;
                        end else if (byteData == CharJ && csiParam == 4'd2) begin
                            cursorRow  <= '0;
                            cursorCol  <= '0;
                            clearCount <= '0;
                            state      <= ConsolePkg::Clearing;
                        end else begin
                            state <= ConsolePkg::Ground;
                        end
                    end
                end
                ConsolePkg::Clearing: begin
                    // One space per cycle across all cells
                    writeEn    <= 1'b1;
                    clearCount <= clearCount + 1'b1;
                    if (clearCount == `COLS * `ROWS - 1) begin
                        state <= ConsolePkg::Ground;
                    end
                end
                default: state <= ConsolePkg::Ground;
            endcase
        end
    end

    // Write address and data ride along with writeEn
    always_ff @(posedge clk) begin
        if (state == ConsolePkg::Clearing) begin
            writeAddr <= clearCount;
            writeChar <= CharSpace;
        end else begin
            writeAddr <= {cursorRow, cursorCol};
            writeChar <= byteData;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        state == ConsolePkg::Clearing |-> !byteReady)
        else $error("byte dropped while the screen was clearing");

endmodule

`default_nettype wire

// ==== dv/VirtualConsoleTb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "console_consts.svh"

module VirtualConsoleTb;

    localparam int Cells = `COLS * `ROWS;
    // Start, eight data bits, stop and one idle bit
    localparam int BitsPerByte = 11;
    localparam int TotalBytes = 253;
    localparam int TotalFrames = 11;
    // A frame is a 200 cycle gap, 130 cycles of scan and a short tail
    localparam int TimeoutCycles = TotalBytes * (BitsPerByte * `CLKS_PER_BIT + 10)
                                 + TotalFrames * 400 + 2000;

    localparam logic [7:0] ByteBs  = 8'h08;
    localparam logic [7:0] ByteLf  = 8'h0A;
    localparam logic [7:0] ByteCr  = 8'h0D;
    localparam logic [7:0] ByteEsc = 8'h1B;

    localparam int ModeGround = 0;
    localparam int ModeEscape = 1;
    localparam int ModeCsi    = 2;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 rxd;
    logic                 frameStart;
    logic                 cellValid;
    logic [7:0]           cellChar;
    logic [`ROW_BITS-1:0] cellRow;
    logic [`COL_BITS-1:0] cellCol;
    logic                 cursorCell;

    // Reference screen, cursor and escape state
    logic [7:0] modelScreen [0:Cells-1];
    int         modelRow;
    int         modelCol;
    int         modelMode;
    int         modelParam;

    logic [7:0] stream [$];
    int         cellIndex = 0;
    int         expectRow;
    int         expectCol;
    logic [7:0] expectChar;
    logic       expectCursor;
    logic       validPrev = 1'b0;
    int         framesSeen = 0;
    int         cursorSeenRow;
    int         cursorSeenCol;
    int         dataErrors = 0;
    int         flowErrors = 0;
    int         cycleCount = 0;

    VirtualConsole i_VirtualConsole(
        .clk,
        .rstN,
        .rxd,
        .frameStart,
        .cellValid,
        .cellChar,
        .cellRow,
        .cellCol,
        .cursorCell
    );

    always #2 clk = ~clk;

    function automatic void applyByte(input logic [7:0] value);
        int i;
        case (modelMode)
            ModeGround: begin
                if (value >= 8'h20 && value <= 8'h7E) begin
                    modelScreen[modelRow * `COLS + modelCol] = value;
                    modelCol = modelCol + 1;
                    if (modelCol == `COLS) begin
                        modelCol = 0;
                        modelRow = (modelRow + 1) % `ROWS;
                    end
                end else if (value == ByteCr) begin
                    modelCol = 0;
                end else if (value == ByteLf) begin
                    modelRow = (modelRow + 1) % `ROWS;
                end else if (value == ByteBs) begin
                    if (modelCol > 0) begin
                        modelCol = modelCol - 1;
                    end
                end else if (value == ByteEsc) begin
                    modelMode = ModeEscape;
                end
            end
            ModeEscape: begin
                modelParam = 0;
                modelMode = (value == 8'h5B) ? ModeCsi : ModeGround;
            end
            default: begin
                if (value >= 8'h30 && value <= 8'h39) begin
                    modelParam = int'(value) - 48;
                end else if (value == 8'h48) begin
                    modelRow = 0;
                    modelCol = 0;
                    modelMode = ModeGround;
                end else if (value == 8'h4A && modelParam == 2) begin
                    for (i = 0; i < Cells; i++) begin
                        modelScreen[i] = 8'h20;
                    end
                    modelRow = 0;
                    modelCol = 0;
                    modelMode = ModeGround;
                end else begin
                    modelMode = ModeGround;
                end
            end
        endcase
    endfunction

    task automatic sendByte(input logic [7:0] value);
        logic [10:0] bits;
        int          i;
        bits = {2'b11, value, 1'b0};
        for (i = 0; i < BitsPerByte; i++) begin
            @(posedge clk);
            rxd <= bits[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge clk);
        end
        applyByte(value);
    endtask

    task automatic sendText(input string text);
        int i;
        for (i = 0; i < text.len(); i++) begin
            sendByte(text[i]);
        end
    endtask

    // Request a frame and wait until the checker has seen it end
    task automatic checkFrame(input logic midPulse);
        int framesBefore;
        framesBefore = framesSeen;
        cursorSeenRow = -1;
        cursorSeenCol = -1;
        repeat (200) @(posedge clk);
        frameStart <= 1'b1;
        @(posedge clk);
        frameStart <= 1'b0;
        if (midPulse) begin
            while (!cellValid) @(posedge clk);
            repeat (60) @(posedge clk);
            frameStart <= 1'b1;
            @(posedge clk);
            frameStart <= 1'b0;
        end
        while (framesSeen == framesBefore) @(posedge clk);
        repeat (20) @(posedge clk);
        if (cellValid || framesSeen != framesBefore + 1) begin
            $display("Scanner started another frame that nobody requested");
            flowErrors++;
        end
    endtask

    task automatic checkCursorSeen(input int row, input int col);
        if (cursorSeenRow != row || cursorSeenCol != col) begin
            $display("Fail at %0t: cursor cell at row %0d col %0d, expected row %0d col %0d",
                     $time, cursorSeenRow, cursorSeenCol, row, col);
            flowErrors++;
        end
    endtask

    task automatic addRandomChunk();
        int kind;
        kind = $urandom % 12;
        case (kind)
            0, 1, 2, 3, 4, 5: stream.push_back(8'h20 + 8'($urandom % 95));
            6: stream.push_back(ByteCr);
            7: stream.push_back(ByteLf);
            8: stream.push_back(ByteBs);
            9: begin
                stream.push_back(ByteEsc);
                if ($urandom % 2 == 0) begin
                    stream.push_back(8'h5B);
                    stream.push_back(8'h48);
                end else begin
                    // ESC c is not supported
                    stream.push_back(8'h63);
                end
            end
            10: begin
                stream.push_back(ByteEsc);
                stream.push_back(8'h5B);
                stream.push_back(8'h30 + 8'($urandom % 4));
                stream.push_back(($urandom % 2 == 0) ? 8'h4A : 8'h6D);
            end
            default: begin
                // Unused controls and bytes above the printable range
                stream.push_back(($urandom % 2 == 0) ? 8'h01 + 8'($urandom % 7)
                                                     : 8'h7F + 8'($urandom % 129));
            end
        endcase
    endtask

    // Frame checker
    always @(posedge clk) begin
        validPrev <= cellValid;
        if (cellValid) begin
            expectRow = (cellIndex % Cells) / `COLS;
            expectCol = cellIndex % `COLS;
            expectChar = modelScreen[cellIndex % Cells];
            expectCursor = (expectRow == modelRow) && (expectCol == modelCol);
            if (int'(cellRow) != expectRow || int'(cellCol) != expectCol) begin
                $display("Fail at %0t: cell %0d at row %0d col %0d, expected row %0d col %0d",
                         $time, cellIndex, cellRow, cellCol, expectRow, expectCol);
                dataErrors++;
            end
            if (cellChar !== expectChar) begin
                $display("Fail at %0t: row %0d col %0d char %h, expected %h",
                         $time, expectRow, expectCol, cellChar, expectChar);
                dataErrors++;
            end
            if (cursorCell !== expectCursor) begin
                $display("Fail at %0t: row %0d col %0d cursor flag %b, expected %b",
                         $time, expectRow, expectCol, cursorCell, expectCursor);
                dataErrors++;
            end
            if (cursorCell) begin
                cursorSeenRow = int'(cellRow);
                cursorSeenCol = int'(cellCol);
            end
            cellIndex++;
        end else if (validPrev) begin
            if (cellIndex != Cells) begin
                $display("Frame %0d had %0d valid cells instead of %0d",
                         framesSeen, cellIndex, Cells);
                dataErrors++;
            end
            framesSeen <= framesSeen + 1;
            cellIndex = 0;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles) begin
            $display("Run timed out after %0d cycles", cycleCount);
            $display("Errors: %0d data, %0d flow", dataErrors, flowErrors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int i;
        rstN = 1'b0;
        rxd = 1'b1;
        frameStart = 1'b0;
        void'($urandom(32'h950c));
        for (i = 0; i < Cells; i++) begin
            modelScreen[i] = 8'h20;
        end
        modelRow = 0;
        modelCol = 0;
        modelMode = ModeGround;
        modelParam = 0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        // Blank screen after reset
        checkFrame(1'b0);
        checkCursorSeen(0, 0);

        // Row 0 fills and wraps into row 1
        sendText("ABCDEFGHIJKLMNOPQRST");
        checkFrame(1'b0);
        checkCursorSeen(1, 4);

        // CR, LF and BS mixed with text
        sendByte(ByteCr);
        sendText("xy");
        repeat (3) sendByte(ByteBs);
        sendText("Z");
        repeat (7) sendByte(ByteLf);
        sendText("Q");
        sendByte(ByteCr);
        sendByte(ByteLf);
        sendText("end");
        checkFrame(1'b0);

        // Cursor home, then clear
        sendByte(ByteEsc);
        sendText("[H");
        sendText("HOME");
        checkFrame(1'b0);
        sendByte(ByteEsc);
        sendText("[2J");
        checkFrame(1'b0);
        checkCursorSeen(0, 0);
        sendText("ok");
        checkFrame(1'b0);

        // Random stream with a frame every 50 bytes
        while (stream.size() < 200) addRandomChunk();
        for (i = 0; i < 200; i++) begin
            sendByte(stream[i]);
            if (i % 50 == 49) begin
                checkFrame(1'b0);
            end
        end

        // Second request in the middle of a scan
        checkFrame(1'b1);

        $display("Errors: %0d data, %0d flow", dataErrors, flowErrors);
        if (dataErrors == 0 && flowErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/console_consts.svh ====
`ifndef CONSOLE_CONSTS_SVH
`define CONSOLE_CONSTS_SVH

// Screen geometry in character cells
`define COLS 16
`define ROWS 8

// Index widths
// Cell address is row * COLS + col
`define COL_BITS 4
`define ROW_BITS 3
`define ADDR_BITS 7

// Clock cycles per serial bit
`define CLKS_PER_BIT 16

`endif
